// File: design/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

////////////////////////////////////////
// Sizing
////////////////////////////////////////

// Entries per FIFO, same for tx and rx
`define UART_FIFO_DEPTH 8

// Register address width, 8 byte-wide slots
`define UART_ADDR_W 3

////////////////////////////////////////
// Reset values
////////////////////////////////////////

// Divisor after reset, {DLM, DLL}
`define UART_DIV_RESET 16'd1

`endif

// File: design/uart_pkg.sv
`include "uart_config.svh"

package uart_pkg;

  // Register bus request, accepted when req is high
  typedef struct packed {
    logic                    req;
    logic                    we;     // 1 = write, 0 = read
    logic [`UART_ADDR_W-1:0] addr;
    logic [7:0]              wdata;
  } uart_bus_req_t;

  // Read response, rvalid one cycle after req
  typedef struct packed {
    logic       rvalid;
    logic [7:0] rdata;
  } uart_bus_rsp_t;

  // Register map
  typedef enum logic [`UART_ADDR_W-1:0] {
    DATA = 0,  // THR on write, RBR on read
    IER  = 1,
    IIR  = 2,  // Read only
    MCR  = 4,  // Bit 4 loopback
    LSR  = 5,  // Read only
    DLL  = 6,
    DLM  = 7
  } uart_reg_e;

  // Register block to the datapath
  typedef struct packed {
    logic [15:0] divisor;
    logic        loopback;
    logic [1:0]  ier;      // [0] rx data, [1] tx empty
    logic        tx_push;
    logic [7:0]  tx_data;
    logic        rx_pop;
    logic        ovr_clr;  // Pulse on LSR read
  } uart_ctrl_t;

  // Datapath status back to registers and interrupts
  typedef struct packed {
    logic [7:0] rx_data;    // Head of rx FIFO
    logic       rx_ferr;
    logic       rx_ready;   // Rx FIFO not empty
    logic       rx_overrun; // Sticky
    logic       tx_empty;   // Tx FIFO empty
    logic       tx_idle;    // Tx FIFO empty, no frame on the line
  } uart_stat_t;

  // FIFO payloads
  typedef logic [7:0] uart_tx_item_t;

  typedef struct packed {
    logic       ferr;  // Stop bit was low
    logic [7:0] data;
  } uart_rx_item_t;

endpackage

// File: design/uart_fifo.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module uart_fifo #(
  parameter type         item_t = logic,
  parameter int unsigned DEPTH  = `UART_FIFO_DEPTH
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  item_t data_i,
  input  logic  pop_i,
  output item_t data_o,   // Head entry, no read latency
  output logic  empty_o,
  output logic  full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  item_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] count_q;  // Occupancy
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;   // Push to full is dropped
  assign do_pop  = pop_i & ~empty_o;   // Pop from empty is ignored
  assign data_o  = mem_q[rptr_q];

  // Pointers and count
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      if (do_pop)  rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      if (do_push && !do_pop)      count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wptr_q] <= data_i;
  end

endmodule

// File: design/uart_register.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module uart_register (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  uart_pkg::uart_bus_req_t bus_req_i,
  output uart_pkg::uart_bus_rsp_t bus_rsp_o,
  input  uart_pkg::uart_stat_t    stat_i,
  input  logic [2:0]              iir_id_i,   // From interrupt encoder
  output uart_pkg::uart_ctrl_t    ctrl_o
);

  localparam logic [15:0] DIV_RESET = `UART_DIV_RESET;

  uart_pkg::uart_reg_e addr;
  logic                wr_en;
  logic                rd_en;
  logic [1:0]          ier_q;
  logic                loopback_q;
  logic [7:0]          dll_q;
  logic [7:0]          dlm_q;
  logic [7:0]          lsr;
  logic [7:0]          rdata_d;
  logic [7:0]          rdata_q;
  logic                rvalid_q;

  assign addr  = uart_pkg::uart_reg_e'(bus_req_i.addr);
  assign wr_en = bus_req_i.req & bus_req_i.we;
  assign rd_en = bus_req_i.req & ~bus_req_i.we;

  ////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ier_q      <= '0;
      loopback_q <= 1'b0;
      dll_q      <= DIV_RESET[7:0];
      dlm_q      <= DIV_RESET[15:8];
    end else if (wr_en) begin
      case (addr)
        uart_pkg::IER: ier_q      <= bus_req_i.wdata[1:0];
        uart_pkg::MCR: loopback_q <= bus_req_i.wdata[4];
        uart_pkg::DLL: dll_q      <= bus_req_i.wdata;
        uart_pkg::DLM: dlm_q      <= bus_req_i.wdata;
        default: ;  // DATA goes to tx FIFO, rest read only
      endcase
    end
  end

  // Strobes are combinational, act at the next edge
  always_comb begin
    ctrl_o          = '0;
    ctrl_o.divisor  = {dlm_q, dll_q};
    ctrl_o.loopback = loopback_q;
    ctrl_o.ier      = ier_q;
    ctrl_o.tx_push  = wr_en & (addr == uart_pkg::DATA);
    ctrl_o.tx_data  = bus_req_i.wdata;
    ctrl_o.rx_pop   = rd_en & (addr == uart_pkg::DATA) & stat_i.rx_ready;
    ctrl_o.ovr_clr  = rd_en & (addr == uart_pkg::LSR);  // Clear after sampling
  end

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////

  // Line status, bits 2, 4 and 7 unused
  assign lsr = {1'b0, stat_i.tx_idle, stat_i.tx_empty, 1'b0,
                stat_i.rx_ferr & stat_i.rx_ready, 1'b0,
                stat_i.rx_overrun, stat_i.rx_ready};

  always_comb begin
    case (addr)
      uart_pkg::DATA: rdata_d = stat_i.rx_ready ? stat_i.rx_data : 8'h00; // 0 when empty
      uart_pkg::IER:  rdata_d = {6'b0, ier_q};
      uart_pkg::IIR:  rdata_d = {5'b0, iir_id_i};
      uart_pkg::MCR:  rdata_d = {3'b0, loopback_q, 4'b0};
      uart_pkg::LSR:  rdata_d = lsr;
      uart_pkg::DLL:  rdata_d = dll_q;
      uart_pkg::DLM:  rdata_d = dlm_q;
      default:        rdata_d = 8'h00;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) rvalid_q <= 1'b0;
    else          rvalid_q <= rd_en;  // Exactly one cycle per read
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) rdata_q <= rdata_d;
  end

  assign bus_rsp_o.rvalid = rvalid_q;
  assign bus_rsp_o.rdata  = rdata_q;

endmodule

// File: design/uart_baudgen.sv
`timescale 1ns/100ps

module uart_baudgen (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  uart_pkg::uart_ctrl_t ctrl_i,
  output logic                 tick16_o   // 16x oversample strobe
);

  logic [15:0] div_eff;
  logic [15:0] cnt_q;
  logic [15:0] div_q;  // Last divisor seen, for restart

  // Divisor 0 behaves as 1
  assign div_eff  = (ctrl_i.divisor == '0) ? 16'd1 : ctrl_i.divisor;
  assign tick16_o = (cnt_q == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      div_q <= '0;
    end else begin
      div_q <= ctrl_i.divisor;
      if (ctrl_i.divisor != div_q) cnt_q <= div_eff - 16'd1;  // Restart on change
      else if (cnt_q == '0)        cnt_q <= div_eff - 16'd1;  // Reload, tick this cycle
      else                         cnt_q <= cnt_q - 16'd1;
    end
  end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  uart_pkg::uart_ctrl_t ctrl_i,
  input  logic                 tick16_i,
  output logic                 txd_o,
  output logic                 tx_empty_o,
  output logic                 tx_idle_o
);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

  tx_state_e               state_q;
  logic [3:0]              tick_cnt_q;
  logic [2:0]              bit_idx_q;
  uart_pkg::uart_tx_item_t shift_q;
  uart_pkg::uart_tx_item_t fifo_data;
  logic                    fifo_empty;
  logic                    fifo_pop;
  logic                    bit_end;

  uart_fifo #(
    .item_t (uart_pkg::uart_tx_item_t)
  ) i_tx_fifo (
    .clk_i,
    .rst_n_i,
    .push_i  (ctrl_i.tx_push),
    .data_i  (ctrl_i.tx_data),
    .pop_i   (fifo_pop),
    .data_o  (fifo_data),
    .empty_o (fifo_empty),
    .full_o  ()              // Writes to full FIFO are dropped inside
  );

  assign bit_end = tick16_i & (tick_cnt_q == 4'hF);  // 16th tick of a bit

  // Frames start on a tick edge, back to back after a stop bit
  assign fifo_pop = ~fifo_empty &
                    (((state_q == TX_IDLE) & tick16_i) | ((state_q == TX_STOP) & bit_end));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= TX_IDLE;
      tick_cnt_q <= '0;
      bit_idx_q  <= '0;
    end else begin
      if (tick16_i) tick_cnt_q <= tick_cnt_q + 4'd1;
      case (state_q)
        TX_IDLE: if (fifo_pop) begin
          state_q    <= TX_START;
          tick_cnt_q <= '0;
        end
        TX_START: if (bit_end) begin
          state_q   <= TX_DATA;
          bit_idx_q <= '0;
        end
        TX_DATA: if (bit_end) begin
          if (bit_idx_q == 3'd7) state_q <= TX_STOP;
          bit_idx_q <= bit_idx_q + 3'd1;
        end
        TX_STOP: if (bit_end) state_q <= fifo_pop ? TX_START : TX_IDLE;
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // LSB first out of bit 0
  always_ff @(posedge clk_i) begin
    if (fifo_pop)                         shift_q <= fifo_data;
    else if (state_q == TX_DATA && bit_end) shift_q <= shift_q >> 1;
  end

  always_comb begin
    case (state_q)
      TX_START: txd_o = 1'b0;
      TX_DATA:  txd_o = shift_q[0];
      default:  txd_o = 1'b1;  // Idle and stop are high
    endcase
  end

  assign tx_empty_o = fifo_empty;
  assign tx_idle_o  = fifo_empty & (state_q == TX_IDLE);

endmodule

// File: design/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  uart_pkg::uart_ctrl_t ctrl_i,
  input  logic                 tick16_i,
  input  logic                 rxd_i,
  output logic [7:0]           rx_data_o,
  output logic                 rx_ferr_o,
  output logic                 rx_ready_o,
  output logic                 rx_overrun_o
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e               state_q;
  logic                    rxd_meta_q;
  logic                    rxd_sync_q;
  logic [3:0]              tick_cnt_q;
  logic [2:0]              bit_idx_q;
  logic [7:0]              shift_q;
  logic                    overrun_q;
  logic                    half_bit;   // 8th tick after the falling edge
  logic                    full_bit;   // 16th tick after last sample
  logic                    stop_done;
  logic                    fifo_full;
  logic                    fifo_empty;
  uart_pkg::uart_rx_item_t push_item;
  uart_pkg::uart_rx_item_t head_item;

  // Two-flop synchronizer, idles high
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rxd_meta_q <= 1'b1;
      rxd_sync_q <= 1'b1;
    end else begin
      rxd_meta_q <= rxd_i;
      rxd_sync_q <= rxd_meta_q;
    end
  end

  assign half_bit  = tick16_i & (tick_cnt_q == 4'd7);
  assign full_bit  = tick16_i & (tick_cnt_q == 4'hF);
  assign stop_done = (state_q == RX_STOP) & full_bit;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= RX_IDLE;
      tick_cnt_q <= '0;
      bit_idx_q  <= '0;
    end else begin
      if (tick16_i) tick_cnt_q <= tick_cnt_q + 4'd1;
      case (state_q)
        RX_IDLE: if (!rxd_sync_q) begin
          state_q    <= RX_START;
          tick_cnt_q <= '0;
        end
        RX_START: if (half_bit) begin
          state_q    <= rxd_sync_q ? RX_IDLE : RX_DATA;  // Glitch goes back to idle
          tick_cnt_q <= '0;                              // Align to bit centre
          bit_idx_q  <= '0;
        end
        RX_DATA: if (full_bit) begin
          if (bit_idx_q == 3'd7) state_q <= RX_STOP;
          bit_idx_q <= bit_idx_q + 3'd1;
        end
        RX_STOP: if (full_bit) state_q <= RX_IDLE;
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Mid-bit sample, LSB arrives first
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && full_bit) shift_q <= {rxd_sync_q, shift_q[7:1]};
  end

  assign push_item.ferr = ~rxd_sync_q;  // Low stop bit
  assign push_item.data = shift_q;

  uart_fifo #(
    .item_t (uart_pkg::uart_rx_item_t)
  ) i_rx_fifo (
    .clk_i,
    .rst_n_i,
    .push_i  (stop_done & ~fifo_full),
    .data_i  (push_item),
    .pop_i   (ctrl_i.rx_pop),
    .data_o  (head_item),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  // Sticky overrun, set wins over clear
  always_ff @(posedge clk_i) begin
    if (!rst_n_i)                    overrun_q <= 1'b0;
    else if (stop_done && fifo_full) overrun_q <= 1'b1;
    else if (ctrl_i.ovr_clr)         overrun_q <= 1'b0;
  end

  assign rx_data_o    = head_item.data;
  assign rx_ferr_o    = head_item.ferr;
  assign rx_ready_o   = ~fifo_empty;
  assign rx_overrun_o = overrun_q;

endmodule

// File: design/uart_interrupts.sv
`timescale 1ns/100ps

module uart_interrupts (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  uart_pkg::uart_ctrl_t ctrl_i,
  input  uart_pkg::uart_stat_t stat_i,
  output logic [2:0]           iir_id_o,
  output logic                 irq_o     // Level, one cycle behind sources
);

  logic src_rx;
  logic src_tx;
  logic irq_q;

  assign src_rx = ctrl_i.ier[0] & stat_i.rx_ready;  // Received data available
  assign src_tx = ctrl_i.ier[1] & stat_i.tx_empty;  // Tx holding empty

  // Rx data has priority over tx empty
  always_comb begin
    if (src_rx)      iir_id_o = 3'b100;
    else if (src_tx) iir_id_o = 3'b010;
    else             iir_id_o = 3'b001;  // None pending
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) irq_q <= 1'b0;
    else          irq_q <= src_rx | src_tx;
  end

  assign irq_o = irq_q;

endmodule

// File: design/uart.sv
`timescale 1ns/100ps

module uart (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  uart_pkg::uart_bus_req_t bus_req_i,
  output uart_pkg::uart_bus_rsp_t bus_rsp_o,
  input  logic                    rxd_i,     // Serial in
  output logic                    txd_o,     // Serial out
  output logic                    irq_o
);

  uart_pkg::uart_ctrl_t ctrl;
  uart_pkg::uart_stat_t stat;
  logic [2:0]           iir_id;
  logic                 tick16;
  logic                 tx_line;  // Raw transmitter output
  logic                 rx_line;  // Receiver input after loopback mux

  ////////////////////////////////////////
  // Registers and baud rate
  ////////////////////////////////////////

  uart_register i_uart_register (
    .clk_i,
    .rst_n_i,
    .bus_req_i,
    .bus_rsp_o,
    .stat_i   (stat),
    .iir_id_i (iir_id),
    .ctrl_o   (ctrl)
  );

  uart_baudgen i_uart_baudgen (
    .clk_i,
    .rst_n_i,
    .ctrl_i   (ctrl),
    .tick16_o (tick16)
  );

  ////////////////////////////////////////
  // Serial datapath
  ////////////////////////////////////////

  // Loopback keeps the pin high and turns tx around into rx
  assign txd_o   = ctrl.loopback ? 1'b1    : tx_line;
  assign rx_line = ctrl.loopback ? tx_line : rxd_i;

  uart_tx i_uart_tx (
    .clk_i,
    .rst_n_i,
    .ctrl_i     (ctrl),
    .tick16_i   (tick16),
    .txd_o      (tx_line),
    .tx_empty_o (stat.tx_empty),
    .tx_idle_o  (stat.tx_idle)
  );

  uart_rx i_uart_rx (
    .clk_i,
    .rst_n_i,
    .ctrl_i       (ctrl),
    .tick16_i     (tick16),
    .rxd_i        (rx_line),
    .rx_data_o    (stat.rx_data),
    .rx_ferr_o    (stat.rx_ferr),
    .rx_ready_o   (stat.rx_ready),
    .rx_overrun_o (stat.rx_overrun)
  );

  uart_interrupts i_uart_interrupts (
    .clk_i,
    .rst_n_i,
    .ctrl_i   (ctrl),
    .stat_i   (stat),
    .iir_id_o (iir_id),
    .irq_o
  );

endmodule

// File: testbench/tb_uart.sv
`timescale 1ns/100ps

module tb_uart;

  localparam int unsigned DIV         = 4;          // Divisor for the serial tests
  localparam int unsigned BIT_CYC     = 16 * DIV;   // Clocks per serial bit
  localparam int unsigned BIT_NS      = BIT_CYC * 4;
  localparam int unsigned FRAME_SLOTS = 20;         // Room for 17 frames plus drain gap and bus traffic
  localparam int unsigned LIMIT_NS    = FRAME_SLOTS * 10 * BIT_NS * 12 / 10;

  logic                    clk;
  logic                    rst_n;
  uart_pkg::uart_bus_req_t bus_req;
  uart_pkg::uart_bus_rsp_t bus_rsp;
  logic                    rxd;
  logic                    txd;
  logic                    irq;
  logic                    txd_watch;  // Set while the pin must stay high

  uart u_uart (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .rxd_i     (rxd),
    .txd_o     (txd),
    .irq_o     (irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    #(LIMIT_NS);
    abort_run("Timeout: the tests ran longer than the expected frame time");
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check(input logic [7:0] actual, input logic [7:0] expected,
                       input string what);
    if (actual !== expected)
      abort_run($sformatf("ERROR at %0t: %s, got 0x%02h, expected 0x%02h",
                          $time, what, actual, expected));
  endtask

  // Loopback pin monitor on the falling edge
  always @(negedge clk) begin
    if (txd_watch) check(8'(txd), 8'd1, "txd_o high during loopback");
  end

  ////////////////////////////////////////
  // Bus and serial helpers
  ////////////////////////////////////////

  task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
    @(posedge clk); #1;
    bus_req.req   = 1'b1;
    bus_req.we    = 1'b1;
    bus_req.addr  = addr;
    bus_req.wdata = data;
    @(posedge clk); #1;  // Write taken at this edge
    bus_req = '0;
  endtask

  task automatic bus_read(input logic [2:0] addr, output logic [7:0] data);
    int cycles;
    cycles = 0;
    @(posedge clk); #1;
    bus_req.req   = 1'b1;
    bus_req.we    = 1'b0;
    bus_req.addr  = addr;
    bus_req.wdata = 8'h00;
    @(posedge clk); #1;
    bus_req = '0;
    while (!bus_rsp.rvalid) begin
      if (cycles == 8) abort_run("Read response never arrived on the bus");
      else begin
        @(posedge clk); #1;
        cycles++;
      end
    end
    data = bus_rsp.rdata;
  endtask

  // Poll LSR until one bit is set
  task automatic wait_lsr_bit(input logic [2:0] idx, input string what);
    logic [7:0] lsr;
    int         polls;
    polls = 0;
    bus_read(uart_pkg::LSR, lsr);
    while (!lsr[idx]) begin
      if (polls == 1000) abort_run($sformatf("Gave up waiting for %s", what));
      else begin
        polls++;
        bus_read(uart_pkg::LSR, lsr);
      end
    end
  endtask

  task automatic drive_bit(input logic b);
    rxd = b;
    repeat (BIT_CYC) @(posedge clk);
    #1;
  endtask

  task automatic serial_send(input logic [7:0] data, input logic stop_bit);
    logic [7:0] shifted;
    shifted = data;
    @(posedge clk); #1;
    drive_bit(1'b0);            // Start
    repeat (8) begin
      drive_bit(shifted[0]);    // LSB first
      shifted = shifted >> 1;
    end
    drive_bit(stop_bit);
    rxd = 1'b1;
  endtask

  task automatic serial_recv(output logic [7:0] data, output logic stop_bit);
    @(negedge txd);
    #(BIT_NS / 2 + 1);          // Middle of the start bit
    check(8'(txd), 8'd0, "tx start bit");
    data = 8'h00;
    repeat (8) begin
      #(BIT_NS);
      data = {txd, data[7:1]};
    end
    #(BIT_NS);
    stop_bit = txd;
  endtask

  // Empty the rx FIFO once the line has settled
  task automatic drain_rx();
    logic [7:0] v;
    repeat (12 * BIT_CYC) @(posedge clk);
    bus_read(uart_pkg::LSR, v);
    while (v[0]) begin
      bus_read(uart_pkg::DATA, v);
      bus_read(uart_pkg::LSR, v);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset_values();
    logic [7:0] v;
    check(8'(txd), 8'd1, "txd_o after reset");
    check(8'(irq), 8'd0, "irq_o after reset");
    check(8'(bus_rsp.rvalid), 8'd0, "rvalid after reset");
    bus_read(uart_pkg::LSR, v);
    check(v, 8'h60, "LSR after reset");
    bus_read(uart_pkg::IIR, v);
    check(v, 8'h01, "IIR after reset");
  endtask

  task automatic test_transmit();
    logic [7:0] to_write[$];
    logic [7:0] expect_q[$];
    logic [7:0] wr_byte;
    logic [7:0] exp_byte;
    logic [7:0] got;
    logic       stop;
    logic [7:0] v;
    bus_write(uart_pkg::DLL, 8'(DIV));
    bus_write(uart_pkg::DLM, 8'h00);
    repeat (3) begin
      wr_byte = 8'($urandom());
      to_write.push_back(wr_byte);
      expect_q.push_back(wr_byte);
    end
    fork
      begin
        while (to_write.size() > 0) begin
          wr_byte = to_write.pop_front();
          bus_write(uart_pkg::DATA, wr_byte);
        end
      end
      begin
        repeat (3) begin
          serial_recv(got, stop);
          exp_byte = expect_q.pop_front();
          check(got, exp_byte, "tx byte on txd_o");
          check(8'(stop), 8'd1, "tx stop bit");
        end
      end
    join
    wait_lsr_bit(3'd6, "transmitter idle");
    bus_read(uart_pkg::LSR, v);
    check(v, 8'h60, "LSR with transmitter idle");  // Tx empty and idle, no rx data
  endtask

  task automatic test_receive();
    logic [7:0] sent[$];
    logic [7:0] b;
    logic [7:0] v;
    repeat (2) begin
      b = 8'($urandom());
      sent.push_back(b);
      serial_send(b, 1'b1);
    end
    wait_lsr_bit(3'd0, "received data");
    while (sent.size() > 0) begin
      b = sent.pop_front();
      bus_read(uart_pkg::DATA, v);
      check(v, b, "rx byte");
    end
    bus_read(uart_pkg::LSR, v);
    check(8'(v[0]), 8'd0, "rx FIFO empty after reads");
    b = 8'($urandom());
    serial_send(b, 1'b0);     // Stop bit held low
    bus_read(uart_pkg::LSR, v);
    check(8'(v[0]), 8'd1, "data ready for bad frame");
    check(8'(v[3]), 8'd1, "framing error flag");
    bus_read(uart_pkg::DATA, v);
    check(v, b, "byte with framing error");
    drain_rx();  // Low stop bit may pass as a new start
  endtask

  task automatic test_overrun();
    logic [7:0] sent[$];
    logic [7:0] b;
    logic [7:0] v;
    repeat (9) begin
      b = 8'($urandom());
      sent.push_back(b);
      serial_send(b, 1'b1);
    end
    bus_read(uart_pkg::LSR, v);
    check(8'(v[1]), 8'd1, "overrun flag set");
    check(8'(v[0]), 8'd1, "data ready with full FIFO");
    repeat (8) begin
      b = sent.pop_front();
      bus_read(uart_pkg::DATA, v);
      check(v, b, "byte kept in full FIFO");
    end
    bus_read(uart_pkg::LSR, v);
    check(8'(v[1]), 8'd0, "overrun cleared by LSR read");
    check(8'(v[0]), 8'd0, "ninth byte dropped");
  endtask

  task automatic test_loopback();
    logic [7:0] b;
    logic [7:0] v;
    b = 8'($urandom());
    bus_write(uart_pkg::MCR, 8'h10);
    txd_watch = 1'b1;
    bus_write(uart_pkg::DATA, b);
    wait_lsr_bit(3'd0, "loopback byte");
    bus_read(uart_pkg::DATA, v);
    check(v, b, "loopback byte");
    wait_lsr_bit(3'd6, "transmitter idle");
    txd_watch = 1'b0;
    bus_write(uart_pkg::MCR, 8'h00);
  endtask

  task automatic test_interrupts();
    logic [7:0] b;
    logic [7:0] v;
    bus_write(uart_pkg::IER, 8'h02);
    @(posedge clk); #1;       // irq registered one cycle after IER
    check(8'(irq), 8'd1, "irq_o with tx empty enabled");
    bus_read(uart_pkg::IIR, v);
    check(v, 8'h02, "IIR tx empty");
    bus_write(uart_pkg::IER, 8'h03);
    b = 8'($urandom());
    serial_send(b, 1'b1);
    bus_read(uart_pkg::IIR, v);
    check(v, 8'h04, "IIR rx data over tx empty");
    bus_read(uart_pkg::DATA, v);
    check(v, b, "byte behind interrupt");
    bus_read(uart_pkg::IIR, v);
    check(v, 8'h02, "IIR back to tx empty");
    bus_write(uart_pkg::IER, 8'h00);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    bus_req   = '0;
    rxd       = 1'b1;  // Line idles high
    rst_n     = 1'b0;
    txd_watch = 1'b0;
    void'($urandom(97));
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_values();
    test_transmit();
    test_receive();
    test_overrun();
    test_loopback();
    test_interrupts();
    $display("Test OK");
    $finish;
  end

endmodule

// File: project.f
+incdir+design
design/uart_pkg.sv
design/uart_fifo.sv
design/uart_register.sv
design/uart_baudgen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_interrupts.sv
design/uart.sv
testbench/tb_uart.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_uart -Mdir obj_dir -o tb_uart_sim

./obj_dir/tb_uart_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

if ! grep -q "Test OK" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
